// File: source/tl_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tl_pkg: bus request and response structs, word types, host
// command types and the system address map
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package tl_pkg;

  // word-level types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  mask_t;

  // host to device request channel
  typedef struct packed {
    logic  a_valid;
    logic  a_write;
    addr_t a_addr;
    data_t a_data;
    mask_t a_mask;
  } tl_h2d_t;

  // device to host response channel
  typedef struct packed {
    logic  d_valid;
    data_t d_data;
    logic  d_error;
  } tl_d2h_t;

  // command from the outside agent to the access port
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    mask_t mask;
  } sba_cmd_t;

  // result handed back to the outside agent
  typedef struct packed {
    data_t rdata;
    logic  error;
  } sba_rsp_t;

  // address map
  parameter addr_t ADDR_SPACE_RAM   = 32'h0000_0000;
  parameter addr_t ADDR_SPACE_GPIO  = 32'h1000_0000;
  parameter addr_t ADDR_SPACE_TIMER = 32'h1001_0000;

  // bits set here are offset bits inside a space
  parameter addr_t ADDR_MASK_RAM    = 32'h000F_FFFF;
  parameter addr_t ADDR_MASK_GPIO   = 32'h0000_FFFF;
  parameter addr_t ADDR_MASK_TIMER  = 32'h0000_FFFF;

endpackage

`default_nettype wire

// File: source/sba_host.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sba_host: system bus access port, turns strobed word commands
// into bus requests and returns one response per command
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sba_host (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               cmd_req_i,
  input  wire tl_pkg::sba_cmd_t   cmd_i,
  output logic                    busy_o,
  output logic                    rsp_valid_o,
  output tl_pkg::sba_rsp_t        rsp_o,
  output tl_pkg::tl_h2d_t         tl_o,
  input  wire logic               tl_ready_i,
  input  wire tl_pkg::tl_d2h_t    tl_i
);

  import tl_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StReq,
    StWait
  } state_e;

  state_e   state_q;
  sba_cmd_t cmd_q;
  sba_rsp_t rsp_q;
  logic     rsp_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= StIdle;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        StIdle: if (cmd_req_i) state_q <= StReq;
        // a_valid stays up until the crossbar takes it
        StReq:  if (tl_ready_i) state_q <= StWait;
        StWait: begin
          if (tl_i.d_valid) begin
            rsp_valid_q <= 1'b1;
            state_q     <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // command and result payload
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && cmd_req_i) begin
      cmd_q <= cmd_i;
    end
    if (state_q == StWait && tl_i.d_valid) begin
      rsp_q.rdata <= tl_i.d_data;
      rsp_q.error <= tl_i.d_error;
    end
  end

  always_comb begin
    tl_o.a_valid = (state_q == StReq);
    tl_o.a_write = cmd_q.write;
    tl_o.a_addr  = cmd_q.addr;
    tl_o.a_data  = cmd_q.wdata;
    tl_o.a_mask  = cmd_q.mask;
  end

  // busy covers the response cycle too
  assign busy_o      = (state_q != StIdle) || rsp_valid_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: source/xbar_main.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// xbar_main: address decode, single outstanding transfer and a
// one-entry response buffer between the host and three devices
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module xbar_main #(
  parameter int RamDepth = 256
) (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire tl_pkg::tl_h2d_t    tl_host_i,
  output tl_pkg::tl_d2h_t         tl_host_o,
  output logic                    tl_host_ready_o,
  output tl_pkg::tl_h2d_t         tl_ram_o,
  input  wire tl_pkg::tl_d2h_t    tl_ram_i,
  output tl_pkg::tl_h2d_t         tl_gpio_o,
  input  wire tl_pkg::tl_d2h_t    tl_gpio_i,
  output tl_pkg::tl_h2d_t         tl_timer_o,
  input  wire tl_pkg::tl_d2h_t    tl_timer_i
);

  import tl_pkg::*;

  localparam addr_t RamBytes = addr_t'(RamDepth * 4);

  localparam logic [1:0] SelRam   = 2'd0;
  localparam logic [1:0] SelGpio  = 2'd1;
  localparam logic [1:0] SelTimer = 2'd2;
  localparam logic [1:0] SelErr   = 2'd3;

  logic [1:0] sel;
  logic [1:0] sel_q;
  logic       accept;
  logic       pend_q;
  logic       rsp_valid_q;
  data_t      rsp_data_q;
  logic       rsp_err_q;
  tl_d2h_t    dev_rsp;

  // decode, RAM also range-checked against its depth
  always_comb begin
    if (((tl_host_i.a_addr & ~ADDR_MASK_RAM) == ADDR_SPACE_RAM) &&
        ((tl_host_i.a_addr & ADDR_MASK_RAM) < RamBytes)) begin
      sel = SelRam;
    end else if ((tl_host_i.a_addr & ~ADDR_MASK_GPIO) == ADDR_SPACE_GPIO) begin
      sel = SelGpio;
    end else if ((tl_host_i.a_addr & ~ADDR_MASK_TIMER) == ADDR_SPACE_TIMER) begin
      sel = SelTimer;
    end else begin
      sel = SelErr;
    end
  end

  assign tl_host_ready_o = !pend_q && !rsp_valid_q;
  assign accept          = tl_host_i.a_valid && tl_host_ready_o;

  always_comb begin
    tl_ram_o           = tl_host_i;
    tl_gpio_o          = tl_host_i;
    tl_timer_o         = tl_host_i;
    tl_ram_o.a_valid   = accept && (sel == SelRam);
    tl_gpio_o.a_valid  = accept && (sel == SelGpio);
    tl_timer_o.a_valid = accept && (sel == SelTimer);
  end

  // response of the device picked at accept time
  always_comb begin
    case (sel_q)
      SelRam:   dev_rsp = tl_ram_i;
      SelGpio:  dev_rsp = tl_gpio_i;
      SelTimer: dev_rsp = tl_timer_i;
      default:  dev_rsp = '{d_valid: 1'b1, d_data: '0, d_error: 1'b1};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
      sel_q       <= SelErr;
    end else begin
      rsp_valid_q <= pend_q && dev_rsp.d_valid;
      if (accept) begin
        pend_q <= 1'b1;
        sel_q  <= sel;
      end else if (pend_q && dev_rsp.d_valid) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pend_q && dev_rsp.d_valid) begin
      rsp_data_q <= dev_rsp.d_data;
      rsp_err_q  <= dev_rsp.d_error;
    end
  end

  assign tl_host_o = '{d_valid: rsp_valid_q, d_data: rsp_data_q, d_error: rsp_err_q};

endmodule

`default_nettype wire

// File: source/ram_main.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ram_main: single-port word memory on the bus, byte-maskable writes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ram_main #(
  parameter int RamDepth = 256
) (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire tl_pkg::tl_h2d_t    tl_i,
  output tl_pkg::tl_d2h_t         tl_o
);

  import tl_pkg::*;

  localparam int IdxW  = $clog2(RamDepth);
  localparam int Bytes = $bits(mask_t);

  data_t           mem [RamDepth];
  logic [IdxW-1:0] idx;
  data_t           rdata_q;
  logic            rvalid_q;

  // word index, bits above the depth are dropped
  assign idx = tl_i.a_addr[2 +: IdxW];

  always_ff @(posedge clk_i) begin
    if (tl_i.a_valid) begin
      if (tl_i.a_write) begin
        for (int b = 0; b < Bytes; b++) begin
          if (tl_i.a_mask[b]) begin
            mem[idx][8*b +: 8] <= tl_i.a_data[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= tl_i.a_valid;
    end
  end

  // range is checked upstream, so no error here
  assign tl_o = '{d_valid: rvalid_q, d_data: rdata_q, d_error: 1'b0};

endmodule

`default_nettype wire

// File: source/gpio.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gpio: output and enable registers, synchronized inputs and
// rising-edge interrupts behind a bus register file
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module gpio #(
  parameter int GpioWidth = 8
) (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire tl_pkg::tl_h2d_t      tl_i,
  output tl_pkg::tl_d2h_t           tl_o,
  input  wire logic [GpioWidth-1:0] gpio_i,
  output logic [GpioWidth-1:0]      gpio_o,
  output logic [GpioWidth-1:0]      gpio_en_o,
  output logic [GpioWidth-1:0]      intr_o
);

  import tl_pkg::*;

  localparam addr_t OffDataOut = 32'h00;
  localparam addr_t OffOutEn   = 32'h04;
  localparam addr_t OffDataIn  = 32'h08;
  localparam addr_t OffIntrEn  = 32'h0C;
  localparam addr_t OffIntrSt  = 32'h10;

  addr_t                offset;
  logic                 wr;
  data_t                rdata;
  logic                 err;
  logic [GpioWidth-1:0] data_out_q, out_en_q, intr_en_q, intr_st_q;
  logic [GpioWidth-1:0] sync1_q, sync2_q, prev_q, rise;
  logic                 rvalid_q;
  data_t                rdata_q;
  logic                 err_q;

  assign offset = tl_i.a_addr & ADDR_MASK_GPIO;
  assign wr     = tl_i.a_valid && tl_i.a_write;
  assign rise   = sync2_q & ~prev_q;

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (offset)
      OffDataOut: rdata = data_t'(data_out_q);
      OffOutEn:   rdata = data_t'(out_en_q);
      OffDataIn: begin
        rdata = data_t'(sync2_q);
        // input register is read-only
        err   = tl_i.a_write;
      end
      OffIntrEn:  rdata = data_t'(intr_en_q);
      OffIntrSt:  rdata = data_t'(intr_st_q);
      default:    err = 1'b1;
    endcase
    if (tl_i.a_write) rdata = '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_out_q <= '0;
      out_en_q   <= '0;
      intr_en_q  <= '0;
      intr_st_q  <= '0;
      sync1_q    <= '0;
      sync2_q    <= '0;
      prev_q     <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      rvalid_q <= tl_i.a_valid;
      if (wr && offset == OffDataOut) data_out_q <= tl_i.a_data[GpioWidth-1:0];
      if (wr && offset == OffOutEn)   out_en_q   <= tl_i.a_data[GpioWidth-1:0];
      if (wr && offset == OffIntrEn)  intr_en_q  <= tl_i.a_data[GpioWidth-1:0];
      // a new edge wins over a clear in the same cycle
      if (wr && offset == OffIntrSt) begin
        intr_st_q <= (intr_st_q & ~tl_i.a_data[GpioWidth-1:0]) | rise;
      end else begin
        intr_st_q <= intr_st_q | rise;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_i.a_valid) begin
      rdata_q <= rdata;
      err_q   <= err;
    end
  end

  assign tl_o      = '{d_valid: rvalid_q, d_data: rdata_q, d_error: err_q};
  assign gpio_o    = data_out_q;
  assign gpio_en_o = out_en_q;
  assign intr_o    = intr_st_q & intr_en_q;

endmodule

`default_nettype wire

// File: source/rv_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv_timer: free-running mtime counter with a compare register
// and a sticky expiry interrupt
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module rv_timer (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire tl_pkg::tl_h2d_t    tl_i,
  output tl_pkg::tl_d2h_t         tl_o,
  output logic                    intr_o
);

  import tl_pkg::*;

  localparam addr_t OffMtime    = 32'h0;
  localparam addr_t OffMtimecmp = 32'h4;
  localparam addr_t OffCtrl     = 32'h8;
  localparam addr_t OffIntrSt   = 32'hC;

  addr_t offset;
  logic  wr;
  data_t rdata, rdata_q;
  logic  err, err_q, rvalid_q;
  data_t mtime_q, mtimecmp_q;
  logic  enable_q, intr_q;

  assign offset = tl_i.a_addr & ADDR_MASK_TIMER;
  assign wr     = tl_i.a_valid && tl_i.a_write;

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (offset)
      OffMtime:    rdata = mtime_q;
      OffMtimecmp: rdata = mtimecmp_q;
      OffCtrl:     rdata = data_t'(enable_q);
      OffIntrSt:   rdata = data_t'(intr_q);
      default:     err = 1'b1;
    endcase
    if (tl_i.a_write) rdata = '0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      enable_q   <= 1'b0;
      intr_q     <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= tl_i.a_valid;
      // bus write overrides the count
      if (wr && offset == OffMtime) mtime_q <= tl_i.a_data;
      else if (enable_q)            mtime_q <= mtime_q + 32'd1;
      if (wr && offset == OffMtimecmp) mtimecmp_q <= tl_i.a_data;
      if (wr && offset == OffCtrl)     enable_q   <= tl_i.a_data[0];
      if (enable_q && mtime_q >= mtimecmp_q)            intr_q <= 1'b1;
      else if (wr && offset == OffIntrSt && tl_i.a_data[0]) intr_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_i.a_valid) begin
      rdata_q <= rdata;
      err_q   <= err;
    end
  end

  assign tl_o   = '{d_valid: rvalid_q, d_data: rdata_q, d_error: err_q};
  assign intr_o = intr_q;

endmodule

`default_nettype wire

// File: source/mini_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini_top: access port, main crossbar, RAM, GPIO and timer,
// plus the combined interrupt vector
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mini_top #(
  parameter int RamDepth  = 256,
  parameter int GpioWidth = 8
) (
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,
  input  wire logic                 cmd_req_i,
  input  wire tl_pkg::sba_cmd_t     cmd_i,
  output logic                      busy_o,
  output logic                      rsp_valid_o,
  output tl_pkg::sba_rsp_t          rsp_o,
  input  wire logic [GpioWidth-1:0] gpio_i,
  output logic [GpioWidth-1:0]      gpio_o,
  output logic [GpioWidth-1:0]      gpio_en_o,
  output logic [GpioWidth:0]        intr_o
);

  import tl_pkg::*;

  tl_h2d_t tl_host_h2d, tl_ram_h2d, tl_gpio_h2d, tl_timer_h2d;
  tl_d2h_t tl_host_d2h, tl_ram_d2h, tl_gpio_d2h, tl_timer_d2h;
  logic    host_ready;

  logic [GpioWidth-1:0] intr_gpio;
  logic                 intr_timer;

  sba_host u_sba_host (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_req_i   (cmd_req_i),
    .cmd_i       (cmd_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .tl_o        (tl_host_h2d),
    .tl_ready_i  (host_ready),
    .tl_i        (tl_host_d2h)
  );

  xbar_main #(
    .RamDepth (RamDepth)
  ) u_xbar_main (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .tl_host_i       (tl_host_h2d),
    .tl_host_o       (tl_host_d2h),
    .tl_host_ready_o (host_ready),
    .tl_ram_o        (tl_ram_h2d),
    .tl_ram_i        (tl_ram_d2h),
    .tl_gpio_o       (tl_gpio_h2d),
    .tl_gpio_i       (tl_gpio_d2h),
    .tl_timer_o      (tl_timer_h2d),
    .tl_timer_i      (tl_timer_d2h)
  );

  ram_main #(
    .RamDepth (RamDepth)
  ) u_ram_main (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .tl_i    (tl_ram_h2d),
    .tl_o    (tl_ram_d2h)
  );

  gpio #(
    .GpioWidth (GpioWidth)
  ) u_gpio (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .tl_i      (tl_gpio_h2d),
    .tl_o      (tl_gpio_d2h),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (intr_gpio)
  );

  rv_timer u_rv_timer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .tl_i    (tl_timer_h2d),
    .tl_o    (tl_timer_d2h),
    .intr_o  (intr_timer)
  );

  // timer expiry on top, gpio bits below
  assign intr_o = {intr_timer, intr_gpio};

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_clock: testbench clock and synchronous reset source
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // reset released on a rising edge
  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: verification/mini_top_properties.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini_top_properties: handshake and reset assertions on the
// system bus access port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mini_top_properties (
  input wire logic clk_i,
  input wire logic reset_i,
  input wire logic cmd_req_i,
  input wire logic busy_o,
  input wire logic rsp_valid_o
);

  // a command pulse is only legal while the port is free
  no_req_while_busy: assert property (
    @(posedge clk_i) disable iff (reset_i) busy_o |-> !cmd_req_i
  ) else $error("command pulse while the access port is busy");

  rsp_valid_single_pulse: assert property (
    @(posedge clk_i) disable iff (reset_i) rsp_valid_o |=> !rsp_valid_o
  ) else $error("response valid held for more than one cycle");

  // outputs idle right after a reset edge
  idle_after_reset: assert property (
    @(posedge clk_i) reset_i |=> (!busy_o && !rsp_valid_o)
  ) else $error("busy or response valid high after reset");

endmodule

`default_nettype wire

// File: verification/tb_mini_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_mini_top: drives bus accesses through the access port and checks
// RAM, GPIO, timer and address map responses against a model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mini_top;

  import tl_pkg::*;

  localparam int RamDepth      = 256;
  localparam int GpioWidth     = 8;
  localparam int RamWindow     = 16;
  localparam int RandAccesses  = 24;
  localparam int RspTimeout    = 12;
  localparam int PollMax       = 20;
  // ram, address error, gpio and timer accesses
  localparam int TotalAccesses = RamWindow + 2 * RandAccesses + 16 + 10 + 8 + PollMax;
  localparam int TimeoutCycles = TotalAccesses * 10 + 200;

  logic                 clk;
  logic                 reset;
  logic                 cmd_req_i;
  sba_cmd_t             cmd_i;
  logic                 busy_o;
  logic                 rsp_valid_o;
  sba_rsp_t             rsp_o;
  logic [GpioWidth-1:0] gpio_i;
  logic [GpioWidth-1:0] gpio_o;
  logic [GpioWidth-1:0] gpio_en_o;
  logic [GpioWidth:0]   intr_o;

  int error_count;

  // model state
  data_t                ram_m [RamDepth];
  logic [GpioWidth-1:0] out_m, en_m, in_m, intr_en_m, intr_st_m;
  logic                 timer_en_m;

  // expected responses waiting for rsp_valid_o
  sba_rsp_t exp_q [$];
  string    name_q [$];

  tb_clock #(.PeriodNs(40), .ResetCycles(4)) u_clock (.clk_o(clk), .reset_o(reset));

  mini_top #(
    .RamDepth  (RamDepth),
    .GpioWidth (GpioWidth)
  ) mini_top_i (
    .clk_i       (clk),
    .reset_i     (reset),
    .cmd_req_i   (cmd_req_i),
    .cmd_i       (cmd_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_o      (intr_o)
  );

  bind sba_host mini_top_properties u_props (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_req_i   (cmd_req_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o)
  );

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    if (expected !== actual) begin
      error_count++;
      $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  // expected result of one access, updates the model on writes
  function automatic sba_rsp_t model_access(input logic write, input addr_t addr,
                                            input data_t wdata, input mask_t mask);
    sba_rsp_t r;
    addr_t    off;
    int       idx;
    r.rdata = '0;
    r.error = 1'b0;
    if (((addr & ~ADDR_MASK_RAM) == ADDR_SPACE_RAM) && (addr < addr_t'(RamDepth * 4))) begin
      idx = int'(addr[31:2]);
      if (write) begin
        for (int b = 0; b < 4; b++) begin
          if (mask[b]) ram_m[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end else begin
        r.rdata = ram_m[idx];
      end
    end else if ((addr & ~ADDR_MASK_GPIO) == ADDR_SPACE_GPIO) begin
      off = addr & ADDR_MASK_GPIO;
      case (off)
        32'h00: if (write) out_m = wdata[GpioWidth-1:0]; else r.rdata = data_t'(out_m);
        32'h04: if (write) en_m = wdata[GpioWidth-1:0]; else r.rdata = data_t'(en_m);
        32'h08: if (write) r.error = 1'b1; else r.rdata = data_t'(in_m);
        32'h0C: if (write) intr_en_m = wdata[GpioWidth-1:0]; else r.rdata = data_t'(intr_en_m);
        32'h10: begin
          if (write) intr_st_m = intr_st_m & ~wdata[GpioWidth-1:0];
          else r.rdata = data_t'(intr_st_m);
        end
        default: r.error = 1'b1;
      endcase
    end else if ((addr & ~ADDR_MASK_TIMER) == ADDR_SPACE_TIMER) begin
      off = addr & ADDR_MASK_TIMER;
      // only ctrl is modeled for reads
      if (off == 32'h8) begin
        if (write) timer_en_m = wdata[0]; else r.rdata = data_t'(timer_en_m);
      end else if (off > 32'hC) begin
        r.error = 1'b1;
      end
    end else begin
      r.error = 1'b1;
    end
    return r;
  endfunction

  // one command through the access port, latency checked
  task automatic bus_access(input string name, input logic check, input sba_rsp_t exp,
                            input logic write, input addr_t addr, input data_t wdata,
                            input mask_t mask, output sba_rsp_t rsp);
    int       cycles;
    sba_cmd_t cmd;
    cmd.write = write;
    cmd.addr  = addr;
    cmd.wdata = wdata;
    cmd.mask  = mask;
    @(posedge clk);
    cmd_req_i <= 1'b1;
    cmd_i     <= cmd;
    if (check) begin
      exp_q.push_back(exp);
      name_q.push_back(name);
    end
    @(posedge clk);
    cmd_req_i <= 1'b0;
    @(negedge clk);
    // edges counted from the one that took the pulse
    cycles = 0;
    check_value({name, " busy"}, 32'd1, data_t'(busy_o));
    while (!rsp_valid_o && cycles < RspTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!rsp_valid_o) begin
      error_count++;
      $display("Error: %s got no response within %0d cycles", name, cycles);
    end else begin
      check_value({name, " latency"}, 32'd3, data_t'(cycles));
    end
    rsp = rsp_o;
  endtask

  task automatic checked_access(input string name, input logic write, input addr_t addr,
                                input data_t wdata, input mask_t mask);
    sba_rsp_t exp;
    sba_rsp_t rsp;
    exp = model_access(write, addr, wdata, mask);
    bus_access(name, 1'b1, exp, write, addr, wdata, mask, rsp);
  endtask

  task automatic raw_read(input string name, input addr_t addr, output sba_rsp_t rsp);
    bus_access(name, 1'b0, '0, 1'b0, addr, '0, '0, rsp);
  endtask

  // drive the pins and hold them long enough to pass the synchronizer
  task automatic set_gpio_in(input logic [GpioWidth-1:0] value);
    @(posedge clk);
    gpio_i    <= value;
    intr_st_m = intr_st_m | (value & ~in_m);
    in_m      = value;
    repeat (4) @(posedge clk);
  endtask

  always @(negedge clk) begin
    if (!reset && rsp_valid_o && exp_q.size() > 0) begin
      check_value({name_q[0], " rdata"}, exp_q[0].rdata, rsp_o.rdata);
      check_value({name_q[0], " error"}, data_t'(exp_q[0].error), data_t'(rsp_o.error));
      void'(exp_q.pop_front());
      void'(name_q.pop_front());
    end
  end

  task automatic test_ram();
    addr_t a;
    for (int i = 0; i < RamWindow; i++) begin
      checked_access("ram init", 1'b1, addr_t'(i * 4), $urandom, 4'hF);
    end
    for (int i = 0; i < RandAccesses; i++) begin
      a = addr_t'(($urandom % RamWindow) * 4);
      checked_access("ram masked write", 1'b1, a, $urandom, mask_t'($urandom));
    end
    for (int i = 0; i < RandAccesses; i++) begin
      a = addr_t'(($urandom % RamWindow) * 4);
      checked_access("ram read", 1'b0, a, '0, 4'hF);
    end
  endtask

  task automatic test_errors();
    addr_t bad [6];
    bad[0] = addr_t'(RamDepth * 4);
    bad[1] = addr_t'(RamDepth * 4 + 20);
    bad[2] = 32'h000F_FFFC;
    bad[3] = 32'h2000_0000;
    bad[4] = 32'h1002_0000;
    bad[5] = 32'hFFFF_FFF0;
    foreach (bad[i]) begin
      checked_access("unmapped write", 1'b1, bad[i], $urandom, 4'hF);
      checked_access("unmapped read", 1'b0, bad[i], '0, 4'hF);
    end
    checked_access("gpio bad offset", 1'b0, ADDR_SPACE_GPIO + 32'h14, '0, 4'hF);
    checked_access("timer bad offset", 1'b0, ADDR_SPACE_TIMER + 32'h10, '0, 4'hF);
    // words 0 and 5 would be hit if the past-depth writes aliased
    checked_access("ram read back", 1'b0, 32'h0, '0, 4'hF);
    checked_access("ram read back", 1'b0, 32'h14, '0, 4'hF);
  endtask

  task automatic test_gpio_io();
    checked_access("gpio data_out write", 1'b1, ADDR_SPACE_GPIO, $urandom, 4'hF);
    checked_access("gpio oe write", 1'b1, ADDR_SPACE_GPIO + 32'h4, $urandom, 4'hF);
    check_value("gpio_o pins", data_t'(out_m), data_t'(gpio_o));
    check_value("gpio_en_o pins", data_t'(en_m), data_t'(gpio_en_o));
    checked_access("gpio data_out read", 1'b0, ADDR_SPACE_GPIO, '0, 4'hF);
    checked_access("gpio oe read", 1'b0, ADDR_SPACE_GPIO + 32'h4, '0, 4'hF);
    set_gpio_in(GpioWidth'($urandom));
    checked_access("gpio data_in read", 1'b0, ADDR_SPACE_GPIO + 32'h8, '0, 4'hF);
    checked_access("gpio data_in write", 1'b1, ADDR_SPACE_GPIO + 32'h8, $urandom, 4'hF);
  endtask

  task automatic test_gpio_intr();
    logic [GpioWidth-1:0] en;
    logic [GpioWidth-1:0] raise;
    en    = GpioWidth'($urandom) | GpioWidth'(1);
    raise = GpioWidth'($urandom) | GpioWidth'(1);
    set_gpio_in('0);
    checked_access("gpio intr clear all", 1'b1, ADDR_SPACE_GPIO + 32'h10, '1, 4'hF);
    checked_access("gpio intr enable", 1'b1, ADDR_SPACE_GPIO + 32'hC, data_t'(en), 4'hF);
    set_gpio_in(raise);
    @(negedge clk);
    check_value("gpio intr raised", data_t'(raise & en), data_t'(intr_o[GpioWidth-1:0]));
    checked_access("gpio intr_state read", 1'b0, ADDR_SPACE_GPIO + 32'h10, '0, 4'hF);
    checked_access("gpio intr clear", 1'b1, ADDR_SPACE_GPIO + 32'h10, data_t'(raise), 4'hF);
    check_value("gpio intr cleared", '0, data_t'(intr_o[GpioWidth-1:0]));
  endtask

  task automatic test_timer();
    sba_rsp_t rsp;
    int       polls;
    logic     found;
    polls = 0;
    found = 1'b0;
    checked_access("timer mtime write", 1'b1, ADDR_SPACE_TIMER, 32'd0, 4'hF);
    checked_access("timer cmp write", 1'b1, ADDR_SPACE_TIMER + 32'h4, 32'd50, 4'hF);
    checked_access("timer enable", 1'b1, ADDR_SPACE_TIMER + 32'h8, 32'd1, 4'hF);
    raw_read("timer first read", ADDR_SPACE_TIMER, rsp);
    check_value("timer first read error", '0, data_t'(rsp.error));
    check_value("timer intr early", '0, data_t'(intr_o[GpioWidth]));
    while (!found && polls < PollMax) begin
      raw_read("timer poll", ADDR_SPACE_TIMER, rsp);
      check_value("timer poll error", '0, data_t'(rsp.error));
      polls++;
      if (rsp.rdata >= 32'd50) found = 1'b1;
    end
    if (!found) begin
      error_count++;
      $display("Error: mtime did not reach the compare value in %0d polls", polls);
    end
    check_value("timer intr expired", 32'd1, data_t'(intr_o[GpioWidth]));
    checked_access("timer disable", 1'b1, ADDR_SPACE_TIMER + 32'h8, 32'd0, 4'hF);
    checked_access("timer intr clear", 1'b1, ADDR_SPACE_TIMER + 32'hC, 32'd1, 4'hF);
    check_value("timer intr cleared", '0, data_t'(intr_o[GpioWidth]));
    checked_access("timer ctrl read", 1'b0, ADDR_SPACE_TIMER + 32'h8, '0, 4'hF);
  endtask

  initial begin
    cmd_req_i   = 1'b0;
    cmd_i       = '0;
    gpio_i      = '0;
    error_count = 0;
    out_m       = '0;
    en_m        = '0;
    in_m        = '0;
    intr_en_m   = '0;
    intr_st_m   = '0;
    timer_en_m  = 1'b0;
    void'($urandom(32'h2b18_cc9c));
    @(posedge clk);
    while (reset) @(posedge clk);
    test_ram();
    test_errors();
    test_gpio_io();
    test_gpio_intr();
    test_timer();
    repeat (4) @(negedge clk);
    $display("Run finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Error: run timed out after %0d cycles with %0d errors", TimeoutCycles,
             error_count);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
source/tl_pkg.sv
source/sba_host.sv
source/xbar_main.sv
source/ram_main.sv
source/gpio.sv
source/rv_timer.sv
source/mini_top.sv
verification/tb_clock.sv
verification/mini_top_properties.sv
verification/tb_mini_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the mini_top regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mini_top -f vlog.f \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_mini_top > sim.log 2>&1
grep -q "Regression failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Regression passed" sim.log || { echo "FAIL, run did not complete"; exit 1; }
echo "PASS"
exit 0
